// File: source/lq_pkg.sv
`default_nettype none

package lq_pkg;

    // ==================================================
    // Width types
    // ==================================================

    // One 32-bit word of load address
    typedef logic [31:0] addr_t;
    // One 32-bit word of load data
    typedef logic [31:0] data_t;
    // ROB index whose age is taken relative to the ROB head modulo 128
    typedef logic [6:0]  rob_idx_t;
    // Physical destination register
    typedef logic [5:0]  preg_t;

    // ==================================================
    // Bundles
    // ==================================================

    // One dispatch lane
    typedef struct packed {
        preg_t    prd;
        rob_idx_t rob_idx;
    } lq_dispatch_t;

    // Request toward the data cache
    typedef struct packed {
        addr_t    addr;
        rob_idx_t rob_idx;
        preg_t    prd;
    } lq_cache_req_t;

    // Data cache response, matched back by ROB index
    typedef struct packed {
        rob_idx_t rob_idx;
        data_t    data;
    } lq_cache_resp_t;

    // Result bus payload
    typedef struct packed {
        preg_t    prd;
        data_t    data;
        rob_idx_t rob_idx;
    } lq_result_t;

    // One slot of the load queue ring
    typedef struct packed {
        logic     valid;
        addr_t    addr;
        logic     addr_valid;
        data_t    data;
        logic     data_valid;
        preg_t    prd;
        rob_idx_t rob_idx;
        logic     executed;
        logic     broadcast;
    } lq_entry_t;

endpackage

`default_nettype wire

// File: source/lq_oldest_select.sv
`timescale 1ns/10ps
`default_nettype none

module lq_oldest_select #(
    parameter int LQ_ENTRIES = 32
) (
    input  logic [LQ_ENTRIES-1:0]         ready,
    input  logic [$clog2(LQ_ENTRIES)-1:0] head_idx,
    output logic                          found,
    output logic [$clog2(LQ_ENTRIES)-1:0] sel_idx
);

    localparam int IDX_W = $clog2(LQ_ENTRIES);

    // ==================================================
    // Oldest-first search around the ring
    // ==================================================

    // Slot head_idx is the oldest, slot head_idx-1 the youngest
    // Index arithmetic wraps by truncation since the size is a power of two
    always_comb begin
        logic [IDX_W-1:0] scan_idx;

        found   = 1'b0;
        sel_idx = '0;
        for (int i = 0; i < LQ_ENTRIES; i++) begin
            scan_idx = head_idx + IDX_W'(i);
            // First hit in age order wins
            if (!found && ready[scan_idx]) begin
                found   = 1'b1;
                sel_idx = scan_idx;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/lq_entry_table.sv
`timescale 1ns/10ps
`default_nettype none

module lq_entry_table #(
    parameter int LQ_ENTRIES     = 32,
    parameter int DISPATCH_WIDTH = 4
) (
    input  logic clk,
    input  logic rst,

    // Dispatch lanes
    input  logic [DISPATCH_WIDTH-1:0]                          dispatch_valid,
    input  logic [DISPATCH_WIDTH-1:0]                          dispatch_is_load,
    input  lq_pkg::lq_dispatch_t [DISPATCH_WIDTH-1:0]          dispatch,
    output logic [DISPATCH_WIDTH-1:0]                          dispatch_lq_valid,
    output logic [DISPATCH_WIDTH-1:0][$clog2(LQ_ENTRIES)-1:0] dispatch_lq_idx,
    output logic                                               lq_full,
    output logic                                               lq_empty,
    output logic [$clog2(LQ_ENTRIES):0]                        lq_count,

    // Address generation
    input  logic             addr_valid,
    input  lq_pkg::rob_idx_t addr_rob_idx,
    input  lq_pkg::addr_t    addr_value,

    // Toward and from the two selectors
    output logic [$clog2(LQ_ENTRIES)-1:0] head_idx,
    output logic [LQ_ENTRIES-1:0]         issue_ready,
    output logic [LQ_ENTRIES-1:0]         bcast_ready,
    input  logic                          issue_found,
    input  logic [$clog2(LQ_ENTRIES)-1:0] issue_idx,
    input  logic                          bcast_found,
    input  logic [$clog2(LQ_ENTRIES)-1:0] bcast_idx,

    // Data cache
    output logic                   cache_req_valid,
    output lq_pkg::lq_cache_req_t  cache_req,
    input  logic                   cache_resp_valid,
    input  lq_pkg::lq_cache_resp_t cache_resp,

    // Result bus
    output logic               result_valid,
    output lq_pkg::lq_result_t result,
    input  logic               result_ack,

    // Commit and flush from the ROB
    input  logic             commit_valid,
    input  lq_pkg::rob_idx_t commit_rob_idx,
    input  logic             flush,
    input  lq_pkg::rob_idx_t flush_rob_idx,
    input  lq_pkg::rob_idx_t rob_head_idx
);

    import lq_pkg::*;

    localparam int IDX_W = $clog2(LQ_ENTRIES);
    // Pointers carry one extra wrap bit
    localparam int PTR_W = IDX_W + 1;

    // ==================================================
    // Storage and pointers
    // ==================================================

    lq_entry_t entries [LQ_ENTRIES];

    logic [PTR_W-1:0]      head_ptr;
    logic [PTR_W-1:0]      tail_ptr;
    logic [PTR_W-1:0]      count;
    logic [PTR_W-1:0]      alloc_tail;
    logic [PTR_W-1:0]      survive_cnt;
    logic [LQ_ENTRIES-1:0] flush_kill;
    logic                  commit_hit;

    assign head_idx = head_ptr[IDX_W-1:0];

    // Occupancy is the pointer distance, wrap bit included
    assign count    = tail_ptr - head_ptr;
    assign lq_count = count;
    assign lq_full  = (count == PTR_W'(LQ_ENTRIES));
    assign lq_empty = (count == '0);

    // ==================================================
    // Dispatch allocation
    // ==================================================

    // Each accepted lane takes the next slot after the lanes before it
    always_comb begin
        logic [PTR_W-1:0] run_tail;
        logic             lane_ok;

        run_tail = tail_ptr;
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            // Room left once the earlier lanes are counted in
            lane_ok = dispatch_valid[i] && dispatch_is_load[i] &&
                      (PTR_W'(run_tail - head_ptr) != PTR_W'(LQ_ENTRIES));
            dispatch_lq_valid[i] = lane_ok;
            dispatch_lq_idx[i]   = run_tail[IDX_W-1:0];
            if (lane_ok) begin
                run_tail = run_tail + PTR_W'(1);
            end
        end
        alloc_tail = run_tail;
    end

    // ==================================================
    // Readiness and payloads
    // ==================================================

    always_comb begin
        for (int i = 0; i < LQ_ENTRIES; i++) begin
            // Addressed, no data yet, not sent to the cache
            issue_ready[i] = entries[i].valid && entries[i].addr_valid &&
                             !entries[i].data_valid && !entries[i].executed;
            // Data back, result not yet taken by the bus
            bcast_ready[i] = entries[i].valid && entries[i].data_valid &&
                             !entries[i].broadcast;
        end
    end

    assign cache_req_valid   = issue_found;
    assign cache_req.addr    = entries[issue_idx].addr;
    assign cache_req.rob_idx = entries[issue_idx].rob_idx;
    assign cache_req.prd     = entries[issue_idx].prd;

    // Held steady while result_ack is low since the entry state does not move
    assign result_valid   = bcast_found;
    assign result.prd     = entries[bcast_idx].prd;
    assign result.data    = entries[bcast_idx].data;
    assign result.rob_idx = entries[bcast_idx].rob_idx;

    // Only the head can leave at commit
    assign commit_hit = commit_valid && entries[head_idx].valid &&
                        (entries[head_idx].rob_idx == commit_rob_idx);

    // ==================================================
    // Flush selection
    // ==================================================

    // Ages are measured from the ROB head so a wrapped ROB index still orders
    always_comb begin
        rob_idx_t flush_rel;
        rob_idx_t entry_rel;

        flush_rel   = flush_rob_idx - rob_head_idx;
        survive_cnt = '0;
        for (int i = 0; i < LQ_ENTRIES; i++) begin
            entry_rel     = entries[i].rob_idx - rob_head_idx;
            flush_kill[i] = entries[i].valid && (entry_rel >= flush_rel);
            if (entries[i].valid && !flush_kill[i]) begin
                survive_cnt = survive_cnt + PTR_W'(1);
            end
        end
    end

    // ==================================================
    // State update
    // ==================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            for (int i = 0; i < LQ_ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else if (flush) begin
            // Survivors are the oldest ones, packed from the head
            for (int i = 0; i < LQ_ENTRIES; i++) begin
                if (flush_kill[i]) begin
                    entries[i].valid <= 1'b0;
                end
            end
            tail_ptr <= head_ptr + survive_cnt;
        end else begin
            for (int i = 0; i < LQ_ENTRIES; i++) begin
                // Address fill
                if (addr_valid && entries[i].valid && !entries[i].addr_valid &&
                    entries[i].rob_idx == addr_rob_idx) begin
                    entries[i].addr       <= addr_value;
                    entries[i].addr_valid <= 1'b1;
                end
                // Cache data may return in any order
                if (cache_resp_valid && entries[i].valid &&
                    entries[i].rob_idx == cache_resp.rob_idx) begin
                    entries[i].data       <= cache_resp.data;
                    entries[i].data_valid <= 1'b1;
                end
            end

            // No back-pressure from the cache, so a request is sent once seen
            if (cache_req_valid) begin
                entries[issue_idx].executed <= 1'b1;
            end

            if (result_valid && result_ack) begin
                entries[bcast_idx].broadcast <= 1'b1;
            end

            if (commit_hit) begin
                entries[head_idx].valid <= 1'b0;
                head_ptr                <= head_ptr + PTR_W'(1);
            end

            // New entries land in free slots only
            for (int i = 0; i < DISPATCH_WIDTH; i++) begin
                if (dispatch_lq_valid[i]) begin
                    entries[dispatch_lq_idx[i]].valid      <= 1'b1;
                    entries[dispatch_lq_idx[i]].addr_valid <= 1'b0;
                    entries[dispatch_lq_idx[i]].data_valid <= 1'b0;
                    entries[dispatch_lq_idx[i]].executed   <= 1'b0;
                    entries[dispatch_lq_idx[i]].broadcast  <= 1'b0;
                    entries[dispatch_lq_idx[i]].prd        <= dispatch[i].prd;
                    entries[dispatch_lq_idx[i]].rob_idx    <= dispatch[i].rob_idx;
                end
            end
            tail_ptr <= alloc_tail;
        end
    end

endmodule

`default_nettype wire

// File: source/load_queue.sv
`timescale 1ns/10ps
`default_nettype none

module load_queue #(
    parameter int LQ_ENTRIES     = 32,
    parameter int DISPATCH_WIDTH = 4
) (
    input  logic clk,
    input  logic rst,

    // Dispatch
    input  logic [DISPATCH_WIDTH-1:0]                          dispatch_valid,
    input  logic [DISPATCH_WIDTH-1:0]                          dispatch_is_load,
    input  lq_pkg::lq_dispatch_t [DISPATCH_WIDTH-1:0]          dispatch,
    output logic [DISPATCH_WIDTH-1:0]                          dispatch_lq_valid,
    output logic [DISPATCH_WIDTH-1:0][$clog2(LQ_ENTRIES)-1:0] dispatch_lq_idx,
    output logic                                               lq_full,

    // Address fill
    input  logic             addr_valid,
    input  lq_pkg::rob_idx_t addr_rob_idx,
    input  lq_pkg::addr_t    addr_value,

    // Data cache
    output logic                   cache_req_valid,
    output lq_pkg::lq_cache_req_t  cache_req,
    input  logic                   cache_resp_valid,
    input  lq_pkg::lq_cache_resp_t cache_resp,

    // Result bus
    output logic               result_valid,
    output lq_pkg::lq_result_t result,
    input  logic               result_ack,

    // Commit
    input  logic             commit_valid,
    input  lq_pkg::rob_idx_t commit_rob_idx,

    // Flush
    input  logic             flush,
    input  lq_pkg::rob_idx_t flush_rob_idx,
    input  lq_pkg::rob_idx_t rob_head_idx,

    // Status
    output logic [$clog2(LQ_ENTRIES):0] lq_count,
    output logic                        lq_empty
);

    localparam int IDX_W = $clog2(LQ_ENTRIES);

    // ==================================================
    // Table to selector wiring
    // ==================================================

    logic [LQ_ENTRIES-1:0] issue_ready;
    logic [LQ_ENTRIES-1:0] bcast_ready;
    logic [IDX_W-1:0]      head_idx;
    logic                  issue_found;
    logic [IDX_W-1:0]      issue_idx;
    logic                  bcast_found;
    logic [IDX_W-1:0]      bcast_idx;

    // Entry storage, pointers and all state updates
    lq_entry_table #(
        .LQ_ENTRIES     (LQ_ENTRIES),
        .DISPATCH_WIDTH (DISPATCH_WIDTH)
    ) u_table (
        .clk               (clk),
        .rst               (rst),
        .dispatch_valid    (dispatch_valid),
        .dispatch_is_load  (dispatch_is_load),
        .dispatch          (dispatch),
        .dispatch_lq_valid (dispatch_lq_valid),
        .dispatch_lq_idx   (dispatch_lq_idx),
        .lq_full           (lq_full),
        .lq_empty          (lq_empty),
        .lq_count          (lq_count),
        .addr_valid        (addr_valid),
        .addr_rob_idx      (addr_rob_idx),
        .addr_value        (addr_value),
        .head_idx          (head_idx),
        .issue_ready       (issue_ready),
        .bcast_ready       (bcast_ready),
        .issue_found       (issue_found),
        .issue_idx         (issue_idx),
        .bcast_found       (bcast_found),
        .bcast_idx         (bcast_idx),
        .cache_req_valid   (cache_req_valid),
        .cache_req         (cache_req),
        .cache_resp_valid  (cache_resp_valid),
        .cache_resp        (cache_resp),
        .result_valid      (result_valid),
        .result            (result),
        .result_ack        (result_ack),
        .commit_valid      (commit_valid),
        .commit_rob_idx    (commit_rob_idx),
        .flush             (flush),
        .flush_rob_idx     (flush_rob_idx),
        .rob_head_idx      (rob_head_idx)
    );

    // Oldest load that can go to the cache
    lq_oldest_select #(
        .LQ_ENTRIES (LQ_ENTRIES)
    ) u_issue_sel (
        .ready    (issue_ready),
        .head_idx (head_idx),
        .found    (issue_found),
        .sel_idx  (issue_idx)
    );

    // Oldest completed load waiting for the result bus
    lq_oldest_select #(
        .LQ_ENTRIES (LQ_ENTRIES)
    ) u_bcast_sel (
        .ready    (bcast_ready),
        .head_idx (head_idx),
        .found    (bcast_found),
        .sel_idx  (bcast_idx)
    );

endmodule

`default_nettype wire

// File: tests/tb_load_queue.sv
`timescale 1ns/10ps
`default_nettype none

module tb_load_queue;

    import lq_pkg::*;

    localparam int LQ_ENTRIES     = 8;
    localparam int DISPATCH_WIDTH = 2;

    logic                         clk;
    logic                         rst;
    logic [1:0]                   dispatch_valid;
    logic [1:0]                   dispatch_is_load;
    lq_dispatch_t [1:0]           dispatch;
    logic [1:0]                   dispatch_lq_valid;
    logic [1:0][2:0]              dispatch_lq_idx;
    logic                         lq_full;
    logic                         addr_valid;
    rob_idx_t                     addr_rob_idx;
    addr_t                        addr_value;
    logic                         cache_req_valid;
    lq_cache_req_t                cache_req;
    logic                         cache_resp_valid;
    lq_cache_resp_t               cache_resp;
    logic                         result_valid;
    lq_result_t                   result;
    logic                         result_ack;
    logic                         commit_valid;
    rob_idx_t                     commit_rob_idx;
    logic                         flush;
    rob_idx_t                     flush_rob_idx;
    rob_idx_t                     rob_head_idx;
    logic [3:0]                   lq_count;
    logic                         lq_empty;

    // Reference model indexed by ROB index
    addr_t m_addr [128];
    data_t m_data [128];
    preg_t m_prd [128];
    bit    m_has_addr [128];
    bit    m_exec [128];
    bit    m_done [128];
    bit    m_bcast [128];

    int          errors;
    int          checks;
    int          test_errs;
    logic [31:0] lcg_state;
    int          pend [$];

    load_queue #(
        .LQ_ENTRIES     (LQ_ENTRIES),
        .DISPATCH_WIDTH (DISPATCH_WIDTH)
    ) DUT (
        .clk (clk), .rst (rst),
        .dispatch_valid (dispatch_valid), .dispatch_is_load (dispatch_is_load),
        .dispatch (dispatch), .dispatch_lq_valid (dispatch_lq_valid),
        .dispatch_lq_idx (dispatch_lq_idx), .lq_full (lq_full),
        .addr_valid (addr_valid), .addr_rob_idx (addr_rob_idx), .addr_value (addr_value),
        .cache_req_valid (cache_req_valid), .cache_req (cache_req),
        .cache_resp_valid (cache_resp_valid), .cache_resp (cache_resp),
        .result_valid (result_valid), .result (result), .result_ack (result_ack),
        .commit_valid (commit_valid), .commit_rob_idx (commit_rob_idx),
        .flush (flush), .flush_rob_idx (flush_rob_idx), .rob_head_idx (rob_head_idx),
        .lq_count (lq_count), .lq_empty (lq_empty)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // ==================================================
    // Helpers
    // ==================================================

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic timed_out(string what);
        $display("Timeout while waiting for %s at %0t", what, $time);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_idx(string name, int got, int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERROR %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_req(string name, lq_cache_req_t got, lq_cache_req_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_res(string name, lq_result_t got, lq_result_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic end_test(string name);
        if (errors == test_errs) begin
            $display("test %s: ok (0 errors)", name);
        end else begin
            $display("test %s: failed (%0d errors)", name, errors - test_errs);
        end
        test_errs = errors;
    endtask

    // Oldest ROB index in [base, base+n) in each state
    // A return of -1 means no such load
    function automatic int oldest_issue(int base, int n);
        for (int r = base; r < base + n; r++) begin
            if (m_has_addr[r] && !m_exec[r]) return r;
        end
        return -1;
    endfunction

    function automatic int oldest_bcast(int base, int n);
        for (int r = base; r < base + n; r++) begin
            if (m_done[r] && !m_bcast[r]) return r;
        end
        return -1;
    endfunction

    // One dispatch cycle with prd derived from the ROB index
    task automatic disp(logic [1:0] vmask, logic [1:0] lmask, int r0, int r1,
                        logic [1:0] emask, int i0, int i1);
        int r [2];

        r[0] = r0;
        r[1] = r1;
        dispatch_valid   = vmask;
        dispatch_is_load = lmask;
        for (int l = 0; l < 2; l++) begin
            dispatch[l].rob_idx = rob_idx_t'(r[l]);
            dispatch[l].prd     = preg_t'(r[l]) ^ 6'h2a;
        end
        #1;
        check_bit("dispatch_lq_valid[0]", dispatch_lq_valid[0], emask[0]);
        check_bit("dispatch_lq_valid[1]", dispatch_lq_valid[1], emask[1]);
        if (emask[0]) check_idx("dispatch_lq_idx[0]", int'(dispatch_lq_idx[0]), i0);
        if (emask[1]) check_idx("dispatch_lq_idx[1]", int'(dispatch_lq_idx[1]), i1);
        for (int l = 0; l < 2; l++) begin
            if (emask[l]) begin
                m_prd[r[l] % 128]      = preg_t'(r[l]) ^ 6'h2a;
                m_has_addr[r[l] % 128] = 0;
                m_exec[r[l] % 128]     = 0;
                m_done[r[l] % 128]     = 0;
                m_bcast[r[l] % 128]    = 0;
            end
        end
        step();
        dispatch_valid = '0;
    endtask

    // Result bus against the oldest completed load
    task automatic check_result_state(int base, int n);
        int r;

        r = oldest_bcast(base, n);
        check_bit("result_valid", result_valid, r >= 0);
        if (r >= 0) begin
            check_res("result", result, {m_prd[r], m_data[r], rob_idx_t'(r)});
            if (result_ack) m_bcast[r] = 1;
        end
    endtask

    // ==================================================
    // Tests
    // ==================================================

    task automatic test_alloc_full();
        disp(2'b11, 2'b01, 0, 99, 2'b01, 0, 0);
        for (int k = 0; k < 3; k++) begin
            disp(2'b11, 2'b11, 1 + 2 * k, 2 + 2 * k, 2'b11, 1 + 2 * k, 2 + 2 * k);
        end
        // Only one slot left for the pair
        disp(2'b11, 2'b11, 7, 8, 2'b01, 7, 0);
        check_bit("lq_full", lq_full, 1'b1);
        check_idx("lq_count", int'(lq_count), 8);
        disp(2'b11, 2'b11, 9, 10, 2'b00, 0, 0);
        end_test("alloc_full");
    endtask

    task automatic test_issue_order();
        int seen;
        int r;

        seen = 0;
        for (int k = 0; k < 10; k++) begin
            addr_valid = (k < 8);
            if (k < 8) begin
                m_addr[7 - k] = lcg_next();
                addr_rob_idx  = rob_idx_t'(7 - k);
                addr_value    = m_addr[7 - k];
            end
            #1;
            r = oldest_issue(0, 8);
            check_bit("cache_req_valid", cache_req_valid, r >= 0);
            if (r >= 0) begin
                check_req("cache_req", cache_req, {m_addr[r], rob_idx_t'(r), m_prd[r]});
                m_exec[r] = 1;
                seen++;
            end
            if (k < 8) m_has_addr[7 - k] = 1;
            step();
        end
        addr_valid = 1'b0;
        check_idx("issued loads", seen, 8);
        end_test("issue_order");
    endtask

    task automatic test_result_backpressure();
        int perm [8] = '{5, 2, 7, 0, 6, 1, 4, 3};
        int wait_cnt;

        result_ack = 1'b0;
        for (int k = 0; k < 8; k++) begin
            m_data[perm[k]]    = lcg_next();
            cache_resp_valid   = 1'b1;
            cache_resp.rob_idx = rob_idx_t'(perm[k]);
            cache_resp.data    = m_data[perm[k]];
            #1;
            check_result_state(0, 8);
            m_done[perm[k]] = 1;
            step();
        end
        cache_resp_valid = 1'b0;
        result_ack       = 1'b1;
        wait_cnt         = 0;
        while (oldest_bcast(0, 8) >= 0) begin
            if (wait_cnt > 20) timed_out("result acknowledgements");
            wait_cnt++;
            #1;
            check_result_state(0, 8);
            step();
        end
        result_ack = 1'b0;
        check_bit("result_valid", result_valid, 1'b0);
        end_test("result_backpressure");
    endtask

    task automatic test_commit();
        commit_valid   = 1'b1;
        commit_rob_idx = 7'd3;
        step();
        check_idx("lq_count", int'(lq_count), 8);
        for (int r = 0; r < 8; r++) begin
            commit_rob_idx = rob_idx_t'(r);
            step();
            check_idx("lq_count", int'(lq_count), 7 - r);
        end
        commit_valid = 1'b0;
        check_bit("lq_empty", lq_empty, 1'b1);
        end_test("commit");
    endtask

    task automatic test_flush_wrap();
        rob_head_idx = 7'd120;
        disp(2'b11, 2'b11, 124, 125, 2'b11, 0, 1);
        disp(2'b11, 2'b11, 126, 127, 2'b11, 2, 3);
        disp(2'b11, 2'b11, 0, 1, 2'b11, 4, 5);
        disp(2'b11, 2'b11, 2, 3, 2'b11, 6, 7);
        flush         = 1'b1;
        flush_rob_idx = 7'd126;
        step();
        flush = 1'b0;
        check_idx("lq_count", int'(lq_count), 2);
        disp(2'b01, 2'b01, 126, 0, 2'b01, 2, 0);
        // Clear the queue for the next test
        flush         = 1'b1;
        flush_rob_idx = 7'd124;
        step();
        flush = 1'b0;
        check_idx("lq_count", int'(lq_count), 0);
        check_bit("lq_empty", lq_empty, 1'b1);
        end_test("flush_wrap");
    endtask

    task automatic test_random();
        int slot;
        int base;
        int got;
        int issued;
        int cyc;
        int r;

        slot = 0;
        for (int round = 0; round < 3; round++) begin
            base = 20 + 4 * round;
            for (int i = 0; i < 4; i++) begin
                m_addr[base + i] = lcg_next();
                m_data[base + i] = lcg_next();
            end
            disp(2'b11, 2'b11, base, base + 1, 2'b11, slot, (slot + 1) % 8);
            disp(2'b11, 2'b11, base + 2, base + 3, 2'b11, (slot + 2) % 8, (slot + 3) % 8);
            slot       = (slot + 4) % 8;
            got        = 0;
            issued     = 0;
            cyc        = 0;
            result_ack = 1'b1;
            pend.delete();
            while (got < 4) begin
                if (cyc > 60) timed_out("random results");
                addr_valid = (cyc < 4);
                if (cyc < 4) begin
                    addr_rob_idx = rob_idx_t'(base + cyc);
                    addr_value   = m_addr[base + cyc];
                end
                cache_resp_valid = (pend.size() > 0);
                if (pend.size() > 0) begin
                    r                  = pend.pop_front();
                    cache_resp.rob_idx = rob_idx_t'(r);
                    cache_resp.data    = m_data[r];
                end
                #1;
                // Fills in age order keep issue and results in age order
                if (cache_req_valid) begin
                    r = base + issued;
                    check_req("cache_req", cache_req, {m_addr[r], rob_idx_t'(r), m_prd[r]});
                    pend.push_back(r);
                    issued++;
                end
                if (result_valid) begin
                    r = base + got;
                    check_res("result", result, {m_prd[r], m_data[r], rob_idx_t'(r)});
                    got++;
                end
                cyc++;
                step();
            end
            addr_valid       = 1'b0;
            cache_resp_valid = 1'b0;
            result_ack       = 1'b0;
            commit_valid     = 1'b1;
            for (int i = 0; i < 4; i++) begin
                commit_rob_idx = rob_idx_t'(base + i);
                step();
            end
            commit_valid = 1'b0;
            check_bit("lq_empty", lq_empty, 1'b1);
        end
        end_test("random");
    endtask

    // ==================================================
    // Main sequence
    // ==================================================

    initial begin
        errors           = 0;
        checks           = 0;
        test_errs        = 0;
        lcg_state        = 32'h30ca98be;
        rst              = 1'b1;
        dispatch_valid   = '0;
        dispatch_is_load = '0;
        dispatch         = '0;
        addr_valid       = 1'b0;
        addr_rob_idx     = '0;
        addr_value       = '0;
        cache_resp_valid = 1'b0;
        cache_resp       = '0;
        result_ack       = 1'b0;
        commit_valid     = 1'b0;
        commit_rob_idx   = '0;
        flush            = 1'b0;
        flush_rob_idx    = '0;
        rob_head_idx     = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        check_bit("cache_req_valid", cache_req_valid, 1'b0);
        check_bit("result_valid", result_valid, 1'b0);
        check_bit("lq_empty", lq_empty, 1'b1);
        check_idx("lq_count", int'(lq_count), 0);

        test_alloc_full();
        test_issue_order();
        test_result_backpressure();
        test_commit();
        test_flush_wrap();
        test_random();

        $display("tests: 6, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
source/lq_pkg.sv
source/lq_oldest_select.sv
source/lq_entry_table.sv
source/load_queue.sv
tests/tb_load_queue.sv

// File: run.sh
#!/bin/sh
# Build and run the load queue testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_load_queue -o sim_tb || exit 1

out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -qx "Simulation finished: PASS" && exit 0 || exit 1
